// File: src/occamy_pkg.sv
/*
 * Shared definitions for the compute fabric.
 * Bus widths, quadrant and config address map, crossbar port indices,
 * AXI4-Lite channel structs and request/response structs.
 */

package occamy_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // Quadrant address map.
  localparam int unsigned NrQuadrants = 4;
  localparam addr_t QuadrantBaseOffset = 32'h1000_0000;
  localparam addr_t QuadrantAddressSpace = 32'h0000_0100;
  localparam int unsigned QuadrantMemWords = 64;
  localparam int unsigned QuadrantMemIdxWidth = $clog2(QuadrantMemWords);

  // Configuration block.
  localparam addr_t CfgBaseAddr = 32'h0200_0000;
  localparam addr_t CfgAddressSpace = 32'h0000_0100;
  localparam logic [7:0] CfgQuadrantEnOffset = 8'h00;

  // Crossbar ports: quadrants first, then config, then the default port.
  localparam int unsigned NrXbarPorts = NrQuadrants + 2;
  localparam int unsigned XbarIdxWidth = $clog2(NrXbarPorts);
  typedef logic [XbarIdxWidth-1:0] xbar_idx_t;
  localparam xbar_idx_t XbarCfgPort = xbar_idx_t'(NrQuadrants);
  localparam xbar_idx_t XbarDefaultPort = xbar_idx_t'(NrQuadrants + 1);

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } resp_e;

  typedef logic [NrQuadrants-1:0] quadrant_en_t;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_chan_t;

  // Manager-driven side of a link.
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_lite_req_t;

  // Subordinate-driven side of a link.
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_lite_resp_t;

endpackage

// File: src/axi_lite_cut.sv
/*
 * One-entry valid/ready register slice.
 * The payload type is a parameter so one slice serves every channel.
 */

`timescale 1ns/1ps

module axi_lite_cut #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Free slot, or the held entry leaves this cycle.
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// File: src/quadrant_xbar.sv
/*
 * Address-decoding AXI4-Lite demux.
 * Steers host writes and reads to a quadrant, the config block or the
 * default port, one transaction in flight per direction.
 */

`timescale 1ns/1ps

module quadrant_xbar (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  occamy_pkg::axi_lite_req_t                              slv_req_i,
  output occamy_pkg::axi_lite_resp_t                             slv_rsp_o,
  output occamy_pkg::axi_lite_req_t  [occamy_pkg::NrXbarPorts-1:0] mst_req_o,
  input  occamy_pkg::axi_lite_resp_t [occamy_pkg::NrXbarPorts-1:0] mst_rsp_i,
  input  occamy_pkg::quadrant_en_t                               quadrant_en_i
);

  // Write direction.
  logic                  w_busy_q;
  logic                  aw_pend_q;
  logic                  w_pend_q;
  occamy_pkg::xbar_idx_t w_sel_q;
  occamy_pkg::aw_chan_t  aw_q;
  occamy_pkg::w_chan_t   w_q;

  // Read direction.
  logic                  r_busy_q;
  logic                  ar_pend_q;
  occamy_pkg::xbar_idx_t r_sel_q;
  occamy_pkg::ar_chan_t  ar_q;

  logic write_accept;
  logic read_accept;
  logic b_fwd;
  logic r_fwd;
  logic b_done;
  logic r_done;

  // Disabled quadrants fall through to the default port.
  function automatic occamy_pkg::xbar_idx_t decode(input occamy_pkg::addr_t addr,
                                                   input occamy_pkg::quadrant_en_t en);
    occamy_pkg::xbar_idx_t idx;
    occamy_pkg::addr_t     base;
    idx = occamy_pkg::XbarDefaultPort;
    for (int i = 0; i < occamy_pkg::NrQuadrants; i++) begin
      base = occamy_pkg::QuadrantBaseOffset +
             occamy_pkg::addr_t'(i) * occamy_pkg::QuadrantAddressSpace;
      if (en[i] && addr >= base && addr < base + occamy_pkg::QuadrantAddressSpace) begin
        idx = occamy_pkg::xbar_idx_t'(i);
      end
    end
    if (addr >= occamy_pkg::CfgBaseAddr &&
        addr < occamy_pkg::CfgBaseAddr + occamy_pkg::CfgAddressSpace) begin
      idx = occamy_pkg::XbarCfgPort;
    end
    return idx;
  endfunction

  assign write_accept = !w_busy_q && slv_req_i.aw_valid && slv_req_i.w_valid;
  assign read_accept  = !r_busy_q && slv_req_i.ar_valid;

  // Response is only passed up once the request has left.
  assign b_fwd  = w_busy_q && !aw_pend_q && !w_pend_q && mst_rsp_i[w_sel_q].b_valid;
  assign r_fwd  = r_busy_q && !ar_pend_q && mst_rsp_i[r_sel_q].r_valid;
  assign b_done = b_fwd && slv_req_i.b_ready;
  assign r_done = r_fwd && slv_req_i.r_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      w_busy_q  <= 1'b0;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      w_sel_q   <= occamy_pkg::XbarDefaultPort;
      r_busy_q  <= 1'b0;
      ar_pend_q <= 1'b0;
      r_sel_q   <= occamy_pkg::XbarDefaultPort;
    end else begin
      if (write_accept) begin
        w_busy_q  <= 1'b1;
        aw_pend_q <= 1'b1;
        w_pend_q  <= 1'b1;
        w_sel_q   <= decode(slv_req_i.aw.addr, quadrant_en_i);
      end else begin
        if (mst_rsp_i[w_sel_q].aw_ready) aw_pend_q <= 1'b0;
        if (mst_rsp_i[w_sel_q].w_ready) w_pend_q <= 1'b0;
        if (b_done) w_busy_q <= 1'b0;
      end
      if (read_accept) begin
        r_busy_q  <= 1'b1;
        ar_pend_q <= 1'b1;
        r_sel_q   <= decode(slv_req_i.ar.addr, quadrant_en_i);
      end else begin
        if (mst_rsp_i[r_sel_q].ar_ready) ar_pend_q <= 1'b0;
        if (r_done) r_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_accept) begin
      aw_q <= slv_req_i.aw;
      w_q  <= slv_req_i.w;
    end
    if (read_accept) begin
      ar_q <= slv_req_i.ar;
    end
  end

  // Payload is shared, valids and readys go to the selected port only.
  always_comb begin
    for (int p = 0; p < occamy_pkg::NrXbarPorts; p++) begin
      mst_req_o[p]          = '0;
      mst_req_o[p].aw       = aw_q;
      mst_req_o[p].w        = w_q;
      mst_req_o[p].ar       = ar_q;
      mst_req_o[p].aw_valid = aw_pend_q && (w_sel_q == occamy_pkg::xbar_idx_t'(p));
      mst_req_o[p].w_valid  = w_pend_q && (w_sel_q == occamy_pkg::xbar_idx_t'(p));
      mst_req_o[p].b_ready  = w_busy_q && !aw_pend_q && !w_pend_q && slv_req_i.b_ready &&
                              (w_sel_q == occamy_pkg::xbar_idx_t'(p));
      mst_req_o[p].ar_valid = ar_pend_q && (r_sel_q == occamy_pkg::xbar_idx_t'(p));
      mst_req_o[p].r_ready  = r_busy_q && !ar_pend_q && slv_req_i.r_ready &&
                              (r_sel_q == occamy_pkg::xbar_idx_t'(p));
    end
  end

  always_comb begin
    slv_rsp_o          = '0;
    slv_rsp_o.aw_ready = write_accept;
    slv_rsp_o.w_ready  = write_accept;
    slv_rsp_o.b        = mst_rsp_i[w_sel_q].b;
    slv_rsp_o.b_valid  = b_fwd;
    slv_rsp_o.ar_ready = read_accept;
    slv_rsp_o.r        = mst_rsp_i[r_sel_q].r;
    slv_rsp_o.r_valid  = r_fwd;
  end

endmodule

// File: src/quadrant_cfg.sv
/*
 * AXI4-Lite configuration register block.
 * Holds QUADRANT_EN, the per-quadrant enable mask used by the crossbar.
 */

`timescale 1ns/1ps

module quadrant_cfg (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  occamy_pkg::axi_lite_req_t  cfg_req_i,
  output occamy_pkg::axi_lite_resp_t cfg_rsp_o,
  output occamy_pkg::quadrant_en_t   quadrant_en_o
);

  occamy_pkg::quadrant_en_t quadrant_en_q;
  logic                     b_valid_q;
  logic                     r_valid_q;
  occamy_pkg::resp_e        b_resp_q;
  occamy_pkg::r_chan_t      r_q;

  logic write_hs;
  logic read_hs;
  logic aw_hit;
  logic ar_hit;

  assign write_hs = cfg_req_i.aw_valid && cfg_req_i.w_valid && !b_valid_q;
  assign read_hs  = cfg_req_i.ar_valid && !r_valid_q;
  assign aw_hit   = cfg_req_i.aw.addr[7:0] == occamy_pkg::CfgQuadrantEnOffset;
  assign ar_hit   = cfg_req_i.ar.addr[7:0] == occamy_pkg::CfgQuadrantEnOffset;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      quadrant_en_q <= '1;
      b_valid_q     <= 1'b0;
      r_valid_q     <= 1'b0;
    end else begin
      // Mask lives in byte 0.
      if (write_hs && aw_hit && cfg_req_i.w.strb[0]) begin
        quadrant_en_q <= cfg_req_i.w.data[occamy_pkg::NrQuadrants-1:0];
      end
      if (write_hs) b_valid_q <= 1'b1;
      else if (cfg_req_i.b_ready) b_valid_q <= 1'b0;
      if (read_hs) r_valid_q <= 1'b1;
      else if (cfg_req_i.r_ready) r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_hs) begin
      b_resp_q <= aw_hit ? occamy_pkg::OKAY : occamy_pkg::SLVERR;
    end
    if (read_hs) begin
      r_q.data <= ar_hit ? occamy_pkg::data_t'(quadrant_en_q) : '0;
      r_q.resp <= ar_hit ? occamy_pkg::OKAY : occamy_pkg::SLVERR;
    end
  end

  always_comb begin
    cfg_rsp_o          = '0;
    cfg_rsp_o.aw_ready = write_hs;
    cfg_rsp_o.w_ready  = write_hs;
    cfg_rsp_o.b.resp   = b_resp_q;
    cfg_rsp_o.b_valid  = b_valid_q;
    cfg_rsp_o.ar_ready = read_hs;
    cfg_rsp_o.r        = r_q;
    cfg_rsp_o.r_valid  = r_valid_q;
  end

  assign quadrant_en_o = quadrant_en_q;

endmodule

// File: src/quadrant_mem.sv
/*
 * AXI4-Lite scratchpad for one quadrant.
 * 64 words with byte-strobe writes, always answers OKAY.
 */

`timescale 1ns/1ps

module quadrant_mem (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  occamy_pkg::axi_lite_req_t  mem_req_i,
  output occamy_pkg::axi_lite_resp_t mem_rsp_o
);

  occamy_pkg::data_t mem_q [occamy_pkg::QuadrantMemWords];
  occamy_pkg::data_t r_data_q;
  logic              b_valid_q;
  logic              r_valid_q;

  logic [occamy_pkg::QuadrantMemIdxWidth-1:0] w_idx;
  logic [occamy_pkg::QuadrantMemIdxWidth-1:0] r_idx;
  logic write_hs;
  logic read_hs;

  // Word index from address bits 7 to 2.
  assign w_idx = mem_req_i.aw.addr[2 +: occamy_pkg::QuadrantMemIdxWidth];
  assign r_idx = mem_req_i.ar.addr[2 +: occamy_pkg::QuadrantMemIdxWidth];

  // Address and data are taken in the same cycle.
  assign write_hs = mem_req_i.aw_valid && mem_req_i.w_valid && !b_valid_q;
  assign read_hs  = mem_req_i.ar_valid && !r_valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (write_hs) b_valid_q <= 1'b1;
      else if (mem_req_i.b_ready) b_valid_q <= 1'b0;
      if (read_hs) r_valid_q <= 1'b1;
      else if (mem_req_i.r_ready) r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_hs) begin
      for (int b = 0; b < occamy_pkg::StrbWidth; b++) begin
        if (mem_req_i.w.strb[b]) begin
          mem_q[w_idx][b*8 +: 8] <= mem_req_i.w.data[b*8 +: 8];
        end
      end
    end
    // Held until r_ready so the data stays stable.
    if (read_hs) begin
      r_data_q <= mem_q[r_idx];
    end
  end

  always_comb begin
    mem_rsp_o          = '0;
    mem_rsp_o.aw_ready = write_hs;
    mem_rsp_o.w_ready  = write_hs;
    mem_rsp_o.b.resp   = occamy_pkg::OKAY;
    mem_rsp_o.b_valid  = b_valid_q;
    mem_rsp_o.ar_ready = read_hs;
    mem_rsp_o.r.data   = r_data_q;
    mem_rsp_o.r.resp   = occamy_pkg::OKAY;
    mem_rsp_o.r_valid  = r_valid_q;
  end

endmodule

// File: src/occamy_top.sv
/*
 * Compute fabric top level.
 * Host input slices, quadrant crossbar, config block and four scratchpads.
 */

`timescale 1ns/1ps

module occamy_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  occamy_pkg::axi_lite_req_t  host_req_i,
  output occamy_pkg::axi_lite_resp_t host_rsp_o,
  output occamy_pkg::axi_lite_req_t  ext_req_o,
  input  occamy_pkg::axi_lite_resp_t ext_rsp_i
);

  occamy_pkg::axi_lite_req_t  xbar_slv_req;
  occamy_pkg::axi_lite_resp_t xbar_slv_rsp;
  occamy_pkg::axi_lite_req_t  [occamy_pkg::NrXbarPorts-1:0] xbar_mst_req;
  occamy_pkg::axi_lite_resp_t [occamy_pkg::NrXbarPorts-1:0] xbar_mst_rsp;
  occamy_pkg::quadrant_en_t   quadrant_en;

  // Request channels are registered, responses go straight back.
  axi_lite_cut #(.payload_t(occamy_pkg::aw_chan_t)) i_aw_cut (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .valid_i(host_req_i.aw_valid), .ready_o(host_rsp_o.aw_ready), .data_i(host_req_i.aw),
    .valid_o(xbar_slv_req.aw_valid), .ready_i(xbar_slv_rsp.aw_ready), .data_o(xbar_slv_req.aw)
  );
  axi_lite_cut #(.payload_t(occamy_pkg::w_chan_t)) i_w_cut (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .valid_i(host_req_i.w_valid), .ready_o(host_rsp_o.w_ready), .data_i(host_req_i.w),
    .valid_o(xbar_slv_req.w_valid), .ready_i(xbar_slv_rsp.w_ready), .data_o(xbar_slv_req.w)
  );
  axi_lite_cut #(.payload_t(occamy_pkg::ar_chan_t)) i_ar_cut (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .valid_i(host_req_i.ar_valid), .ready_o(host_rsp_o.ar_ready), .data_i(host_req_i.ar),
    .valid_o(xbar_slv_req.ar_valid), .ready_i(xbar_slv_rsp.ar_ready), .data_o(xbar_slv_req.ar)
  );

  assign xbar_slv_req.b_ready = host_req_i.b_ready;
  assign xbar_slv_req.r_ready = host_req_i.r_ready;
  assign host_rsp_o.b         = xbar_slv_rsp.b;
  assign host_rsp_o.b_valid   = xbar_slv_rsp.b_valid;
  assign host_rsp_o.r         = xbar_slv_rsp.r;
  assign host_rsp_o.r_valid   = xbar_slv_rsp.r_valid;

  quadrant_xbar i_xbar (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .slv_req_i(xbar_slv_req), .slv_rsp_o(xbar_slv_rsp),
    .mst_req_o(xbar_mst_req), .mst_rsp_i(xbar_mst_rsp),
    .quadrant_en_i(quadrant_en)
  );

  quadrant_cfg i_cfg (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cfg_req_i(xbar_mst_req[occamy_pkg::XbarCfgPort]),
    .cfg_rsp_o(xbar_mst_rsp[occamy_pkg::XbarCfgPort]),
    .quadrant_en_o(quadrant_en)
  );

  // Unmatched and disabled traffic leaves through the last port.
  assign ext_req_o = xbar_mst_req[occamy_pkg::XbarDefaultPort];
  assign xbar_mst_rsp[occamy_pkg::XbarDefaultPort] = ext_rsp_i;

  for (genvar i = 0; i < occamy_pkg::NrQuadrants; i++) begin : gen_quadrants
    quadrant_mem i_quadrant_mem (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .mem_req_i(xbar_mst_req[i]), .mem_rsp_o(xbar_mst_rsp[i])
    );
  end

endmodule

// File: test/occamy_top_asserts.sv
/*
 * Concurrent AXI4-Lite checks on the crossbar.
 * One downstream write at a time, host b only for an open write,
 * response payload held under back-pressure.
 */

`timescale 1ns/1ps

module occamy_top_asserts (
  input logic                                                   clk_i,
  input logic                                                   rst_n_i,
  input occamy_pkg::axi_lite_req_t                              slv_req_i,
  input occamy_pkg::axi_lite_resp_t                             slv_rsp_i,
  input occamy_pkg::axi_lite_req_t  [occamy_pkg::NrXbarPorts-1:0] mst_req_i
);

  logic [occamy_pkg::NrXbarPorts-1:0] aw_valids;
  logic                               wr_open_q;
  int                                 fail_count;

  always_comb begin
    for (int p = 0; p < occamy_pkg::NrXbarPorts; p++) begin
      aw_valids[p] = mst_req_i[p].aw_valid;
    end
  end

  // Host write open from aw handshake to b handshake.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_open_q <= 1'b0;
    end else if (slv_req_i.aw_valid && slv_rsp_i.aw_ready) begin
      wr_open_q <= 1'b1;
    end else if (slv_rsp_i.b_valid && slv_req_i.b_ready) begin
      wr_open_q <= 1'b0;
    end
  end

  // A downstream aw belongs to an open host write and goes to one port.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|aw_valids) |-> wr_open_q && $onehot(aw_valids))
    else begin
      fail_count++;
      $error("downstream aw_valid at several ports or without an open write");
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) slv_rsp_i.b_valid |-> wr_open_q)
    else begin
      fail_count++;
      $error("host b_valid without an open write");
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_rsp_i.b_valid && !slv_req_i.b_ready |=> slv_rsp_i.b_valid && $stable(slv_rsp_i.b))
    else begin
      fail_count++;
      $error("b response changed under low b_ready");
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_rsp_i.r_valid && !slv_req_i.r_ready |=> slv_rsp_i.r_valid && $stable(slv_rsp_i.r))
    else begin
      fail_count++;
      $error("r response changed under low r_ready");
    end

endmodule

bind quadrant_xbar occamy_top_asserts i_xbar_asserts (
  .clk_i(clk_i), .rst_n_i(rst_n_i),
  .slv_req_i(slv_req_i), .slv_rsp_i(slv_rsp_o), .mst_req_i(mst_req_o)
);

// File: test/tb_occamy_top.sv
/*
 * Directed testbench for the compute fabric top level.
 * Host driver tasks, a default-port memory responder, a quadrant
 * reference model and a cycle watchdog.
 */

`timescale 1ns/1ps

module tb_occamy_top;

  // Bound on the run from fewer than 250 host transactions of at most 20 cycles each.
  localparam int NrTxns        = 250;
  localparam int CyclesPerTxn  = 20;
  localparam int TimeoutCycles = NrTxns * CyclesPerTxn;

  logic                       clk_i;
  logic                       rst_n_i;
  occamy_pkg::axi_lite_req_t  host_req;
  occamy_pkg::axi_lite_resp_t host_rsp;
  occamy_pkg::axi_lite_req_t  ext_req;
  occamy_pkg::axi_lite_resp_t ext_rsp;

  occamy_pkg::data_t ref_mem [occamy_pkg::NrQuadrants][occamy_pkg::QuadrantMemWords];
  occamy_pkg::data_t ext_mem [16];
  occamy_pkg::addr_t ext_last_addr;
  int ext_count;
  int ext_expected;
  int resp_stall;
  int q1_idx;
  int checks;
  int errors;
  int cycle_count;

  occamy_top DUT (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .host_req_i(host_req), .host_rsp_o(host_rsp),
    .ext_req_o(ext_req), .ext_rsp_i(ext_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: no completion after %0d cycles", cycle_count);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic occamy_pkg::data_t byte_merge(input occamy_pkg::data_t old_word,
                                                   input occamy_pkg::data_t new_word,
                                                   input occamy_pkg::strb_t strb);
    occamy_pkg::data_t res;
    res = old_word;
    for (int b = 0; b < occamy_pkg::StrbWidth; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic require_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("Error: %s", what);
    end
  endtask

  // Models an external 16-word memory behind the default port.
  initial begin : ext_responder
    logic aw_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;
    occamy_pkg::aw_chan_t aw_l;
    occamy_pkg::w_chan_t  w_l;
    occamy_pkg::ar_chan_t ar_l;
    for (int i = 0; i < 16; i++) ext_mem[i] = 32'hEE00_0000 | i;
    ext_last_addr = '0;
    forever begin
      @(negedge clk_i);
      aw_hs = ext_req.aw_valid && ext_req.w_valid && ext_rsp.aw_ready;
      b_hs  = ext_rsp.b_valid && ext_req.b_ready;
      ar_hs = ext_req.ar_valid && ext_rsp.ar_ready;
      r_hs  = ext_rsp.r_valid && ext_req.r_ready;
      aw_l  = ext_req.aw;
      w_l   = ext_req.w;
      ar_l  = ext_req.ar;
      @(posedge clk_i);
      #1;
      if (aw_hs) begin
        ext_mem[aw_l.addr[5:2]] = byte_merge(ext_mem[aw_l.addr[5:2]], w_l.data, w_l.strb);
        ext_rsp.b.resp  = occamy_pkg::OKAY;
        ext_rsp.b_valid = 1'b1;
        ext_last_addr   = aw_l.addr;
        ext_count++;
      end else if (b_hs) begin
        ext_rsp.b_valid = 1'b0;
      end
      if (ar_hs) begin
        ext_rsp.r.data  = ext_mem[ar_l.addr[5:2]];
        ext_rsp.r.resp  = occamy_pkg::OKAY;
        ext_rsp.r_valid = 1'b1;
        ext_last_addr   = ar_l.addr;
        ext_count++;
      end else if (r_hs) begin
        ext_rsp.r_valid = 1'b0;
      end
      ext_rsp.aw_ready = !ext_rsp.b_valid;
      ext_rsp.w_ready  = !ext_rsp.b_valid;
      ext_rsp.ar_ready = !ext_rsp.r_valid;
    end
  end

  task automatic axi_write(input occamy_pkg::addr_t addr, input occamy_pkg::data_t data,
                           input occamy_pkg::strb_t strb, input occamy_pkg::resp_e exp_resp);
    logic aw_done;
    logic w_done;
    occamy_pkg::b_chan_t b_seen;
    aw_done = 1'b0;
    w_done  = 1'b0;
    host_req.aw       = '{addr: addr, prot: 3'b000};
    host_req.aw_valid = 1'b1;
    host_req.w        = '{data: data, strb: strb};
    host_req.w_valid  = 1'b1;
    host_req.b_ready  = (resp_stall == 0);
    while (!(aw_done && w_done)) begin
      @(negedge clk_i);
      if (host_req.aw_valid && host_rsp.aw_ready) aw_done = 1'b1;
      if (host_req.w_valid && host_rsp.w_ready) w_done = 1'b1;
      @(posedge clk_i);
      #1;
      if (aw_done) host_req.aw_valid = 1'b0;
      if (w_done) host_req.w_valid = 1'b0;
    end
    @(negedge clk_i);
    while (!host_rsp.b_valid) @(negedge clk_i);
    b_seen = host_rsp.b;
    if (resp_stall > 0) begin
      repeat (resp_stall) begin
        @(posedge clk_i);
        #1;
        @(negedge clk_i);
        require_true(host_rsp.b_valid, "b_valid dropped while b_ready was low");
        compare_value("b.resp", {30'b0, host_rsp.b.resp}, {30'b0, b_seen.resp});
      end
      @(posedge clk_i);
      #1;
      host_req.b_ready = 1'b1;
      @(negedge clk_i);
      require_true(host_rsp.b_valid, "b_valid lost before b_ready rose");
    end
    @(posedge clk_i);
    #1;
    host_req.b_ready = 1'b0;
    compare_value("b.resp", {30'b0, b_seen.resp}, {30'b0, exp_resp});
  endtask

  task automatic axi_read(input occamy_pkg::addr_t addr, input occamy_pkg::data_t exp_data,
                          input occamy_pkg::resp_e exp_resp);
    occamy_pkg::r_chan_t r_seen;
    host_req.ar       = '{addr: addr, prot: 3'b000};
    host_req.ar_valid = 1'b1;
    host_req.r_ready  = (resp_stall == 0);
    @(negedge clk_i);
    while (!host_rsp.ar_ready) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    host_req.ar_valid = 1'b0;
    @(negedge clk_i);
    while (!host_rsp.r_valid) @(negedge clk_i);
    r_seen = host_rsp.r;
    if (resp_stall > 0) begin
      repeat (resp_stall) begin
        @(posedge clk_i);
        #1;
        @(negedge clk_i);
        require_true(host_rsp.r_valid, "r_valid dropped while r_ready was low");
        compare_value("r.data", host_rsp.r.data, r_seen.data);
      end
      @(posedge clk_i);
      #1;
      host_req.r_ready = 1'b1;
      @(negedge clk_i);
      require_true(host_rsp.r_valid, "r_valid lost before r_ready rose");
    end
    @(posedge clk_i);
    #1;
    host_req.r_ready = 1'b0;
    compare_value("r.data", r_seen.data, exp_data);
    compare_value("r.resp", {30'b0, r_seen.resp}, {30'b0, exp_resp});
  endtask

  task automatic read_cfg_after_reset();
    axi_read(occamy_pkg::CfgBaseAddr, 32'h0000_000F, occamy_pkg::OKAY);
  endtask

  // Full write first so the partial merge starts from a known word.
  task automatic merge_quadrant_words();
    occamy_pkg::addr_t addr;
    occamy_pkg::data_t d;
    occamy_pkg::strb_t s;
    int idx;
    for (int q = 0; q < occamy_pkg::NrQuadrants; q++) begin
      for (int k = 0; k < 4; k++) begin
        idx  = $urandom % occamy_pkg::QuadrantMemWords;
        addr = occamy_pkg::QuadrantBaseOffset + q * occamy_pkg::QuadrantAddressSpace + idx * 4;
        d    = $urandom;
        axi_write(addr, d, 4'hF, occamy_pkg::OKAY);
        ref_mem[q][idx] = d;
        d = $urandom;
        s = $urandom % 16;
        axi_write(addr, d, s, occamy_pkg::OKAY);
        ref_mem[q][idx] = byte_merge(ref_mem[q][idx], d, s);
        axi_read(addr, ref_mem[q][idx], occamy_pkg::OKAY);
        if (q == 1) q1_idx = idx;
      end
    end
    compare_value("ext_count", ext_count, ext_expected);
  endtask

  task automatic route_to_default_port();
    occamy_pkg::data_t d;
    d = $urandom;
    axi_write(32'h3000_0000, d, 4'hF, occamy_pkg::OKAY);
    compare_value("ext_req.aw.addr", ext_last_addr, 32'h3000_0000);
    axi_read(32'h3000_0000, d, occamy_pkg::OKAY);
    compare_value("ext_req.ar.addr", ext_last_addr, 32'h3000_0000);
    ext_expected += 2;
    compare_value("ext_count", ext_count, ext_expected);
  endtask

  task automatic disable_quadrant_one();
    occamy_pkg::addr_t addr;
    occamy_pkg::data_t d;
    addr = occamy_pkg::QuadrantBaseOffset + occamy_pkg::QuadrantAddressSpace + q1_idx * 4;
    d    = ~ref_mem[1][q1_idx];
    axi_write(occamy_pkg::CfgBaseAddr, 32'h0000_000D, 4'hF, occamy_pkg::OKAY);
    axi_read(occamy_pkg::CfgBaseAddr, 32'h0000_000D, occamy_pkg::OKAY);
    axi_write(addr, d, 4'hF, occamy_pkg::OKAY);
    compare_value("ext_req.aw.addr", ext_last_addr, addr);
    axi_read(addr, d, occamy_pkg::OKAY);
    compare_value("ext_req.ar.addr", ext_last_addr, addr);
    ext_expected += 2;
    compare_value("ext_count", ext_count, ext_expected);
    axi_write(occamy_pkg::CfgBaseAddr, 32'h0000_000F, 4'hF, occamy_pkg::OKAY);
    axi_read(addr, ref_mem[1][q1_idx], occamy_pkg::OKAY);
    compare_value("ext_count", ext_count, ext_expected);
  endtask

  task automatic access_bad_cfg_offset();
    axi_write(occamy_pkg::CfgBaseAddr + 32'h4, 32'h0000_0003, 4'hF, occamy_pkg::SLVERR);
    axi_read(occamy_pkg::CfgBaseAddr + 32'h4, 32'h0, occamy_pkg::SLVERR);
    axi_read(occamy_pkg::CfgBaseAddr, 32'h0000_000F, occamy_pkg::OKAY);
  endtask

  // Held responses from a quadrant, the config block and the default port.
  task automatic stall_responses();
    occamy_pkg::addr_t addr;
    occamy_pkg::data_t d;
    for (int k = 0; k < 3; k++) begin
      addr = occamy_pkg::QuadrantBaseOffset + 2 * occamy_pkg::QuadrantAddressSpace + k * 4;
      d    = $urandom;
      resp_stall = 1 + $urandom % 8;
      axi_write(addr, d, 4'hF, occamy_pkg::OKAY);
      ref_mem[2][k] = d;
      resp_stall = 1 + $urandom % 8;
      axi_read(addr, ref_mem[2][k], occamy_pkg::OKAY);
    end
    resp_stall = 1 + $urandom % 8;
    axi_read(occamy_pkg::CfgBaseAddr, 32'h0000_000F, occamy_pkg::OKAY);
    d = $urandom;
    resp_stall = 1 + $urandom % 8;
    axi_write(32'h3000_0008, d, 4'hF, occamy_pkg::OKAY);
    resp_stall = 1 + $urandom % 8;
    axi_read(32'h3000_0008, d, occamy_pkg::OKAY);
    ext_expected += 2;
    resp_stall = 0;
    compare_value("ext_count", ext_count, ext_expected);
  endtask

  initial begin
    void'($urandom(5641));
    rst_n_i      = 1'b0;
    host_req     = '0;
    ext_rsp      = '0;
    ext_count    = 0;
    ext_expected = 0;
    resp_stall   = 0;
    q1_idx       = 0;
    checks       = 0;
    errors       = 0;
    cycle_count  = 0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    read_cfg_after_reset();
    merge_quadrant_words();
    route_to_default_port();
    disable_quadrant_one();
    access_bad_cfg_offset();
    stall_responses();
    errors += DUT.i_xbar.i_xbar_asserts.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: src.f
src/occamy_pkg.sv
src/axi_lite_cut.sv
src/quadrant_xbar.sv
src/quadrant_cfg.sv
src/quadrant_mem.sv
src/occamy_top.sv
test/occamy_top_asserts.sv
test/tb_occamy_top.sv

// File: Bender.yml
package:
  name: occamy_fabric

sources:
  - src/occamy_pkg.sv
  - src/axi_lite_cut.sv
  - src/quadrant_xbar.sv
  - src/quadrant_cfg.sv
  - src/quadrant_mem.sv
  - src/occamy_top.sv
  - target: test
    files:
      - test/occamy_top_asserts.sv
      - test/tb_occamy_top.sv
